// ==== project.f ====
+incdir+.
tf_pkg.sv
tf_base_bank.sv
tf_const_table.sv
tf_barrett_mul.sv
tf_gen.sv
tb_tf_gen.sv

// ==== tb_tf_tasks.svh ====
`ifndef TB_TF_TASKS_SVH
`define TB_TF_TASKS_SVH

// reference product, widened to 64 bits so nothing wraps before the reduction
function automatic tf_pkg::word_t mod_mul(input tf_pkg::word_t a, input tf_pkg::word_t b);
	longint unsigned wide;
	wide = a;
	wide = wide * b;
	return tf_pkg::word_t'(wide % tf_pkg::Q);
endfunction

// drives row data from the model into the bank
task automatic load_row(input int row);
	for (int l = 0; l < tf_pkg::LANES; l++) begin
		base_in[l] = model[row][l];
	end
	depth = tf_pkg::depth_t'(row);
	init_base = 1'b1;
	tick();
	init_base = 1'b0;
endtask

task automatic load_table();
	for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
		const_in[e] = ctab[e];
	end
	init_const = 1'b1;
	tick();
	init_const = 1'b0;
endtask

task automatic expect_zero();
	for (int l = 0; l < tf_pkg::LANES; l++) begin
		expect_row[l] = '0;
	end
endtask

task automatic check_lanes();
	for (int l = 0; l < tf_pkg::LANES; l++) begin
		assert (tf_base[l] === expect_row[l])
		else begin
			$display("** Error at %0t ns: tf_base[%0d] expected 0x%04h, got 0x%04h",
				$time, l, expect_row[l], tf_base[l]);
			test_errors++;
		end
	end
endtask

task automatic finish_test(input string name);
	if (test_errors == 0) begin
		$display("test %s: pass", name);
		tests_passed++;
	end else begin
		$display("test %s: fail with %0d mismatches", name, test_errors);
		tests_failed++;
	end
	test_errors = 0;
endtask

`endif

// ==== tb_tf_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tf_gen;

	localparam int WAIT_LIMIT = 64;

	logic           clk;
	logic           rst;
	logic           init_base;
	logic           init_const;
	logic           ren;
	logic           wen;
	tf_pkg::depth_t depth;
	tf_pkg::word_t  base_in [tf_pkg::LANES];
	tf_pkg::word_t  const_in [tf_pkg::CONST_ENTRIES];
	tf_pkg::cidx_t  idx [tf_pkg::LANES];
	tf_pkg::word_t  tf_base [tf_pkg::LANES];

	// reference copies of the bank and the constant table
	tf_pkg::word_t model [tf_pkg::DEPTH][tf_pkg::LANES];
	tf_pkg::word_t ctab [tf_pkg::CONST_ENTRIES];
	tf_pkg::word_t expect_row [tf_pkg::LANES];
	tf_pkg::word_t wb_row [tf_pkg::DEPTH][tf_pkg::LANES];

	int test_errors;
	int tests_passed;
	int tests_failed;

	tf_gen dut (
		.clk        (clk),
		.rst        (rst),
		.init_base  (init_base),
		.init_const (init_const),
		.ren        (ren),
		.wen        (wen),
		.depth      (depth),
		.base_in    (base_in),
		.const_in   (const_in),
		.idx        (idx),
		.tf_base    (tf_base)
	);

	`include "tb_tf_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// inputs change 1 ns after the rising edge and outputs are read at the same point
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		for (int count = 0; count < n; count++) begin
			if (count >= WAIT_LIMIT) begin
				abort_run("idle wait ran past its cycle limit");
			end
			tick();
		end
	endtask

	// draws stay below Q-1 so the forced Q-1 operand is the only one of its kind
	task automatic fill_bank();
		tf_pkg::word_t v;
		bit clash;
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				do begin
					v = tf_pkg::word_t'($urandom % (tf_pkg::Q - 1));
					clash = 1'b0;
					for (int p = 0; p < r * tf_pkg::LANES + l; p++) begin
						if (model[p / tf_pkg::LANES][p % tf_pkg::LANES] == v) begin
							clash = 1'b1;
						end
					end
				end while (clash);
				model[r][l] = v;
			end
		end
		model[1][2] = tf_pkg::Q - 1;
	endtask

	task automatic read_row(input int row);
		for (int l = 0; l < tf_pkg::LANES; l++) begin
			expect_row[l] = model[row][l];
		end
		ren = 1'b1;
		depth = tf_pkg::depth_t'(row);
		tick();
		ren = 1'b0;
		check_lanes();
	endtask

	// products of a read at edge k are valid after edge k+3 and land in the row at k+4
	task automatic read_and_writeback(input int row);
		for (int l = 0; l < tf_pkg::LANES; l++) begin
			wb_row[row][l] = mod_mul(model[row][l], ctab[idx[l]]);
		end
		read_row(row);
		idle_cycles(tf_pkg::MUL_LATENCY);
		wen = 1'b1;
		tick();
		wen = 1'b0;
		model[row] = wb_row[row];
		read_row(row);
	endtask

	initial begin
		void'($urandom(43608));
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rst = 1'b1;
		init_base = 1'b0;
		init_const = 1'b0;
		ren = 1'b0;
		wen = 1'b0;
		depth = '0;
		for (int l = 0; l < tf_pkg::LANES; l++) begin
			base_in[l] = '0;
			idx[l] = '0;
		end
		for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
			const_in[e] = '0;
		end
		idle_cycles(4);
		rst = 1'b0;

		expect_zero();
		check_lanes();
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				model[r][l] = '0;
			end
			read_row(r);
		end
		finish_test("reset state");

		fill_bank();
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			load_row(r);
		end
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			read_row(r);
			tick();
			expect_zero();
			check_lanes();
		end
		finish_test("row load and read");

		for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
			ctab[e] = tf_pkg::word_t'($urandom % tf_pkg::Q);
		end
		ctab[3] = tf_pkg::Q - 1;
		load_table();
		idx[0] = 4'd0;
		idx[1] = 4'd9;
		idx[2] = 4'd3;
		idx[3] = 4'd12;
		read_and_writeback(1);
		finish_test("single product writeback");

		// four reads back to back, each row's products go to the next row up
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				idx[l] = tf_pkg::cidx_t'(r * tf_pkg::LANES + l);
				wb_row[r][l] = mod_mul(model[r][l], ctab[r * tf_pkg::LANES + l]);
				expect_row[l] = model[r][l];
			end
			ren = 1'b1;
			depth = tf_pkg::depth_t'(r);
			tick();
			check_lanes();
		end
		ren = 1'b0;
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			wen = 1'b1;
			depth = tf_pkg::depth_t'((r + 1) % tf_pkg::DEPTH);
			tick();
		end
		wen = 1'b0;
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			model[(r + 1) % tf_pkg::DEPTH] = wb_row[r];
		end
		for (int r = 0; r < tf_pkg::DEPTH; r++) begin
			read_row(r);
		end
		finish_test("pipelined stream");

		// the streaming edge reads the row while the products are written into it
		for (int l = 0; l < tf_pkg::LANES; l++) begin
			idx[l] = tf_pkg::cidx_t'(l + 5);
			wb_row[2][l] = mod_mul(model[2][l], ctab[l + 5]);
		end
		read_row(2);
		idle_cycles(tf_pkg::MUL_LATENCY);
		ren = 1'b1;
		wen = 1'b1;
		tick();
		ren = 1'b0;
		wen = 1'b0;
		check_lanes();
		model[2] = wb_row[2];
		tick();
		read_row(2);
		finish_test("read during writeback");

		for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
			ctab[e] = tf_pkg::word_t'($urandom % tf_pkg::Q);
		end
		load_table();
		idx[0] = 4'd15;
		idx[1] = 4'd6;
		idx[2] = 4'd1;
		idx[3] = 4'd10;
		read_and_writeback(3);
		finish_test("constant reload");

		$display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tf_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tf_gen (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           init_base,
	input  wire logic           init_const,
	input  wire logic           ren,
	input  wire logic           wen,
	input  wire tf_pkg::depth_t depth,
	input  wire tf_pkg::word_t  base_in [tf_pkg::LANES],
	input  wire tf_pkg::word_t  const_in [tf_pkg::CONST_ENTRIES],
	input  wire tf_pkg::cidx_t  idx [tf_pkg::LANES],
	output tf_pkg::word_t       tf_base [tf_pkg::LANES]
);

	// per-lane constant operand from the table
	tf_pkg::word_t tf_const [tf_pkg::LANES];

	// lane products, written back into the bank when wen is raised
	tf_pkg::word_t tf_prod [tf_pkg::LANES];

	tf_base_bank u_base_bank (
		.clk       (clk),
		.rst       (rst),
		.init_base (init_base),
		.ren       (ren),
		.wen       (wen),
		.depth     (depth),
		.base_in   (base_in),
		.wb_in     (tf_prod),
		.tf_base   (tf_base)
	);

	tf_const_table u_const_table (
		.clk        (clk),
		.rst        (rst),
		.init_const (init_const),
		.ren        (ren),
		.const_in   (const_in),
		.idx        (idx),
		.tf_const   (tf_const)
	);

	// one modular multiplier per lane, products come three edges after the read
	for (genvar g = 0; g < tf_pkg::LANES; g++) begin : g_lane
		tf_barrett_mul u_mul (
			.clk    (clk),
			.rst    (rst),
			.a      (tf_base[g]),
			.b      (tf_const[g]),
			.result (tf_prod[g])
		);
	end

endmodule

`default_nettype wire

// ==== tf_barrett_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module tf_barrett_mul (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire tf_pkg::word_t a,
	input  wire tf_pkg::word_t b,
	output tf_pkg::word_t      result
);

	// stage one holds the full product
	tf_pkg::prod_t p1;

	// stage two holds the product and the quotient estimate
	tf_pkg::prod_t p2;
	tf_pkg::word_t q2;

	tf_pkg::prod_t prod_hi;
	tf_pkg::prod_t mu_prod;
	tf_pkg::prod_t q_est;

	tf_pkg::prod_t q_times_mod;
	tf_pkg::prod_t r0;
	tf_pkg::prod_t r1;
	tf_pkg::prod_t r2;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p1 <= '0;
		end else begin
			p1 <= tf_pkg::prod_t'(a) * tf_pkg::prod_t'(b);
		end
	end

	// the estimate floor(floor(p / 2^(K-1)) * mu / 2^(K+1)) undershoots
	// the true quotient by at most two
	always_comb begin
		prod_hi = p1 >> (tf_pkg::BARRETT_K - 1);
		mu_prod = prod_hi * tf_pkg::prod_t'(tf_pkg::BARRETT_MU);
		q_est   = mu_prod >> (tf_pkg::BARRETT_K + 1);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p2 <= '0;
			q2 <= '0;
		end else begin
			p2 <= p1;
			q2 <= q_est[tf_pkg::D_WIDTH-1:0];
		end
	end

	// remainder before correction lies below 3Q
	always_comb begin
		q_times_mod = tf_pkg::prod_t'(q2) * tf_pkg::prod_t'(tf_pkg::Q);
		r0 = p2 - q_times_mod;
		if (r0 >= tf_pkg::prod_t'(tf_pkg::Q)) begin
			r1 = r0 - tf_pkg::prod_t'(tf_pkg::Q);
		end else begin
			r1 = r0;
		end
		if (r1 >= tf_pkg::prod_t'(tf_pkg::Q)) begin
			r2 = r1 - tf_pkg::prod_t'(tf_pkg::Q);
		end else begin
			r2 = r1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result <= '0;
		end else begin
			result <= r2[tf_pkg::D_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== tf_const_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module tf_const_table (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          init_const,
	input  wire logic          ren,
	input  wire tf_pkg::word_t const_in [tf_pkg::CONST_ENTRIES],
	input  wire tf_pkg::cidx_t idx [tf_pkg::LANES],
	output tf_pkg::word_t      tf_const [tf_pkg::LANES]
);

	tf_pkg::word_t table_q [tf_pkg::CONST_ENTRIES];

	// the whole table is replaced in one cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
				table_q[e] <= '0;
			end
		end else if (init_const) begin
			for (int e = 0; e < tf_pkg::CONST_ENTRIES; e++) begin
				table_q[e] <= const_in[e];
			end
		end
	end

	// each lane picks its own entry, so lanes may share or differ freely
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				tf_const[l] <= '0;
			end
		end else begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				if (ren) begin
					tf_const[l] <= table_q[idx[l]];
				end else begin
					tf_const[l] <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tf_base_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module tf_base_bank (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           init_base,
	input  wire logic           ren,
	input  wire logic           wen,
	input  wire tf_pkg::depth_t depth,
	input  wire tf_pkg::word_t  base_in [tf_pkg::LANES],
	input  wire tf_pkg::word_t  wb_in [tf_pkg::LANES],
	output tf_pkg::word_t       tf_base [tf_pkg::LANES]
);

	// one row per iteration depth, one word per lane
	tf_pkg::word_t bank [tf_pkg::DEPTH][tf_pkg::LANES];

	logic          wr_en;
	tf_pkg::word_t wr_data [tf_pkg::LANES];

	// a row is written either from the load port or from the lane products,
	// the two strobes never come together
	always_comb begin
		wr_en = init_base | wen;
		for (int l = 0; l < tf_pkg::LANES; l++) begin
			if (init_base) begin
				wr_data[l] = base_in[l];
			end else begin
				wr_data[l] = wb_in[l];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int d = 0; d < tf_pkg::DEPTH; d++) begin
				for (int l = 0; l < tf_pkg::LANES; l++) begin
					bank[d][l] <= '0;
				end
			end
		end else if (wr_en) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				bank[depth][l] <= wr_data[l];
			end
		end
	end

	// the read samples the row before any write on the same edge lands,
	// so a streaming read of the row being updated returns the old words
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				tf_base[l] <= '0;
			end
		end else if (ren) begin
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				tf_base[l] <= bank[depth][l];
			end
		end else begin
			// idle cycles feed zeros into the multipliers
			for (int l = 0; l < tf_pkg::LANES; l++) begin
				tf_base[l] <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tf_pkg.sv ====
`default_nettype none

package tf_pkg;

	// datapath word and product widths
	localparam int D_WIDTH = 16;

	typedef logic [D_WIDTH-1:0] word_t;
	typedef logic [2*D_WIDTH-1:0] prod_t;

	// lane count and the number of base rows, one per iteration depth
	localparam int LANES = 4;
	localparam int DEPTH = 4;

	typedef logic [$clog2(DEPTH)-1:0] depth_t;

	// twiddle constant table
	localparam int CONST_ENTRIES = 16;

	typedef logic [$clog2(CONST_ENTRIES)-1:0] cidx_t;

	// prime modulus used by every lane
	localparam word_t Q = 16'd12289;

	// Barrett reduction constants, K is the bit length of Q
	// and MU is floor(2^(2K) / Q)
	localparam int BARRETT_K = 14;
	localparam word_t BARRETT_MU = 16'd21843;

	// cycles from registered operands to a valid product
	localparam int MUL_LATENCY = 3;

endpackage

`default_nettype wire
